//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////
    // data widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////

    // primary opcode, bits 31:26
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // r-type function field, bits 5:0
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    ////////////////////////////////////////////////////////////
    // control types
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_slt
    } alu_op_t;

    // writeback source
    typedef enum logic {
        wb_alu, wb_mem
    } wb_sel_t;

endpackage

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  taken,
    input  wire  mips_pkg::word_t target,
    input  wire  mips_pkg::word_t imem_data,
    output mips_pkg::word_t      imem_addr,
    output mips_pkg::word_t      if_pc4,
    output mips_pkg::word_t      if_instr
);
    import mips_pkg::*;

    word_t pc;
    word_t pc4;

    assign pc4       = pc + 32'd4;
    assign imem_addr = pc;

    // decode redirect lands one cycle after the delay slot fetch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (taken) begin
            pc <= target;
        end else begin
            pc <= pc4;
        end
    end

    // IF/ID register, all-zero word decodes as a nop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_instr <= '0;
        end else begin
            if_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if_pc4 <= pc4;
    end

    // branch and jump targets from decode must keep the pc on word boundaries
    a_pc_aligned : assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire  mips_pkg::reg_idx_t rs_idx,
    input  wire  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t         rs_data,
    output mips_pkg::word_t         rt_data,
    input  wire                     wr_en,
    input  wire  mips_pkg::reg_idx_t wr_idx,
    input  wire  mips_pkg::word_t    wr_data
);
    import mips_pkg::*;

    // register 0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // same-cycle write passes straight through to the reader
    assign rs_data = (rs_idx == '0) ? '0 :
                     (wr_en && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 :
                     (wr_en && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

    // writeback from the core may target r0, reads must still see zero
    a_r0_zero : assert property (@(posedge clk) disable iff (!arst_n)
        ((rs_idx == '0) -> (rs_data == '0)) && ((rt_idx == '0) -> (rt_data == '0)))
        else $error("register 0 read nonzero");

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire  mips_pkg::word_t     if_pc4,
    input  wire  mips_pkg::word_t     if_instr,
    input  wire                      wb_en,
    input  wire  mips_pkg::reg_idx_t  wb_reg,
    input  wire  mips_pkg::word_t     wb_data,
    output logic                     taken,
    output mips_pkg::word_t          target,
    output mips_pkg::word_t          ex_rs_data,
    output mips_pkg::word_t          ex_rt_data,
    output mips_pkg::word_t          ex_imm,
    output mips_pkg::reg_idx_t       ex_dst,
    output mips_pkg::alu_op_t        ex_alu_op,
    output logic                     ex_use_imm,
    output logic                     ex_reg_write,
    output logic                     ex_mem_read,
    output logic                     ex_mem_write,
    output mips_pkg::wb_sel_t        ex_wb_sel
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rs_idx;
    reg_idx_t   rt_idx;
    reg_idx_t   rd_idx;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm;

    alu_op_t    alu_op;
    wb_sel_t    wb_sel;
    reg_idx_t   dst;
    logic       use_imm;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       is_beq;
    logic       is_bne;
    logic       is_j;

    assign opcode = if_instr[31:26];
    assign rs_idx = if_instr[25:21];
    assign rt_idx = if_instr[20:16];
    assign rd_idx = if_instr[15:11];
    assign funct  = if_instr[5:0];
    assign imm    = {{16{if_instr[15]}}, if_instr[15:0]};

    reg_file reg_file_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_val),
        .rt_data (rt_val),
        .wr_en   (wb_en),
        .wr_idx  (wb_reg),
        .wr_data (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        alu_op    = alu_add;
        wb_sel    = wb_alu;
        dst       = rd_idx;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (opcode)
            op_rtype: begin
                reg_write = 1'b1;
                case (funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: reg_write = 1'b0;
                endcase
            end
            op_addi: begin
                dst       = rt_idx;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            op_lw: begin
                dst       = rt_idx;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
                wb_sel    = wb_mem;
            end
            op_sw: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            op_beq:  is_beq = 1'b1;
            op_bne:  is_bne = 1'b1;
            op_j:    is_j = 1'b1;
            default: ;
        endcase
    end

    // branches resolve here, the delay slot is already in IF/ID
    assign taken  = is_j || (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
    assign target = is_j ? {if_pc4[31:28], if_instr[25:0], 2'b00}
                         : if_pc4 + {imm[29:0], 2'b00};

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_alu_op    <= alu_add;
            ex_wb_sel    <= wb_alu;
            ex_use_imm   <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_alu_op    <= alu_op;
            ex_wb_sel    <= wb_sel;
            ex_use_imm   <= use_imm;
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs_data <= rs_val;
        ex_rt_data <= rt_val;
        ex_imm     <= imm;
        ex_dst     <= dst;
    end

    a_no_rd_wr : assert property (@(posedge clk) disable iff (!arst_n)
        !(ex_mem_read && ex_mem_write))
        else $error("load and store issued together");

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire  mips_pkg::word_t     ex_rs_data,
    input  wire  mips_pkg::word_t     ex_rt_data,
    input  wire  mips_pkg::word_t     ex_imm,
    input  wire  mips_pkg::reg_idx_t  ex_dst,
    input  wire  mips_pkg::alu_op_t   ex_alu_op,
    input  wire                      ex_use_imm,
    input  wire                      ex_reg_write,
    input  wire                      ex_mem_read,
    input  wire                      ex_mem_write,
    input  wire  mips_pkg::wb_sel_t   ex_wb_sel,
    output mips_pkg::word_t          mem_alu_result,
    output mips_pkg::word_t          mem_store_data,
    output mips_pkg::reg_idx_t       mem_dst,
    output logic                     mem_reg_write,
    output logic                     mem_mem_read,
    output logic                     mem_mem_write,
    output mips_pkg::wb_sel_t        mem_wb_sel
);
    import mips_pkg::*;

    word_t op_b;
    word_t alu_result;

    // immediate for addi, lw and sw address
    assign op_b = ex_use_imm ? ex_imm : ex_rt_data;

    always_comb begin
        case (ex_alu_op)
            alu_add: alu_result = ex_rs_data + op_b;
            alu_sub: alu_result = ex_rs_data - op_b;
            alu_and: alu_result = ex_rs_data & op_b;
            alu_or:  alu_result = ex_rs_data | op_b;
            alu_slt: alu_result = {31'd0, $signed(ex_rs_data) < $signed(op_b)};
            default: alu_result = ex_rs_data + op_b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_wb_sel    <= wb_alu;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_wb_sel    <= ex_wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= alu_result;
        mem_store_data <= ex_rt_data;
        mem_dst        <= ex_dst;
    end

endmodule

`default_nettype wire

//--- memory_stage.sv
`default_nettype none

module memory_stage #(
    parameter int dmem_words = 256
) (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire  mips_pkg::word_t     mem_alu_result,
    input  wire  mips_pkg::word_t     mem_store_data,
    input  wire  mips_pkg::reg_idx_t  mem_dst,
    input  wire                      mem_reg_write,
    input  wire                      mem_mem_read,
    input  wire                      mem_mem_write,
    input  wire  mips_pkg::wb_sel_t   mem_wb_sel,
    output logic                     st_en,
    output mips_pkg::word_t          st_addr,
    output mips_pkg::word_t          st_data,
    output logic                     wb_reg_write,
    output mips_pkg::reg_idx_t       wb_dst,
    output mips_pkg::word_t          wb_alu,
    output mips_pkg::word_t          wb_load,
    output mips_pkg::wb_sel_t        wb_sel
);
    import mips_pkg::*;

    localparam int addr_bits = $clog2(dmem_words);

    word_t                dmem [dmem_words];
    logic [addr_bits-1:0] word_idx;
    word_t                load_data;

    // byte address to word index
    assign word_idx  = mem_alu_result[addr_bits+1:2];
    assign load_data = mem_mem_read ? dmem[word_idx] : '0;

    always_ff @(posedge clk) begin
        if (mem_mem_write) begin
            dmem[word_idx] <= mem_store_data;
        end
    end

    // store is visible in the cycle it commits
    assign st_en   = mem_mem_write;
    assign st_addr = mem_alu_result;
    assign st_data = mem_store_data;

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_reg_write <= 1'b0;
            wb_sel       <= mips_pkg::wb_alu;
        end else begin
            wb_reg_write <= mem_reg_write;
            wb_sel       <= mem_wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        wb_dst  <= mem_dst;
        wb_alu  <= mem_alu_result;
        wb_load <= load_data;
    end

    // the address comes from the execute stage adder
    a_addr_ok : assert property (@(posedge clk) disable iff (!arst_n)
        (mem_mem_read || mem_mem_write) |->
            (mem_alu_result[1:0] == 2'b00 && mem_alu_result < 32'(dmem_words * 4)))
        else $error("bad data address: %h", mem_alu_result);

endmodule

`default_nettype wire

//--- mips_core.sv
`default_nettype none

module mips_core #(
    parameter int dmem_words = 256
) (
    input  wire                     clk,
    input  wire                     arst_n,
    output mips_pkg::word_t         imem_addr,
    input  wire  mips_pkg::word_t    imem_data,
    output logic                    wb_en,
    output mips_pkg::reg_idx_t      wb_reg,
    output mips_pkg::word_t         wb_data,
    output logic                    st_en,
    output mips_pkg::word_t         st_addr,
    output mips_pkg::word_t         st_data
);
    import mips_pkg::*;

    // fetch to decode and back
    word_t    if_pc4;
    word_t    if_instr;
    logic     taken;
    word_t    target;

    // ID/EX
    word_t    ex_rs_data;
    word_t    ex_rt_data;
    word_t    ex_imm;
    reg_idx_t ex_dst;
    alu_op_t  ex_alu_op;
    logic     ex_use_imm;
    logic     ex_reg_write;
    logic     ex_mem_read;
    logic     ex_mem_write;
    wb_sel_t  ex_wb_sel;

    // EX/MEM
    word_t    mem_alu_result;
    word_t    mem_store_data;
    reg_idx_t mem_dst;
    logic     mem_reg_write;
    logic     mem_mem_read;
    logic     mem_mem_write;
    wb_sel_t  mem_wb_sel;

    // MEM/WB
    logic     memwb_reg_write;
    reg_idx_t memwb_dst;
    word_t    memwb_alu;
    word_t    memwb_load;
    wb_sel_t  memwb_sel;

    fetch_stage fetch_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .taken     (taken),
        .target    (target),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .if_pc4    (if_pc4),
        .if_instr  (if_instr)
    );

    decode_stage decode_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .if_pc4       (if_pc4),
        .if_instr     (if_instr),
        .wb_en        (wb_en),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .taken        (taken),
        .target       (target),
        .ex_rs_data   (ex_rs_data),
        .ex_rt_data   (ex_rt_data),
        .ex_imm       (ex_imm),
        .ex_dst       (ex_dst),
        .ex_alu_op    (ex_alu_op),
        .ex_use_imm   (ex_use_imm),
        .ex_reg_write (ex_reg_write),
        .ex_mem_read  (ex_mem_read),
        .ex_mem_write (ex_mem_write),
        .ex_wb_sel    (ex_wb_sel)
    );

    execute_stage execute_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .ex_rs_data     (ex_rs_data),
        .ex_rt_data     (ex_rt_data),
        .ex_imm         (ex_imm),
        .ex_dst         (ex_dst),
        .ex_alu_op      (ex_alu_op),
        .ex_use_imm     (ex_use_imm),
        .ex_reg_write   (ex_reg_write),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write),
        .ex_wb_sel      (ex_wb_sel),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_dst        (mem_dst),
        .mem_reg_write  (mem_reg_write),
        .mem_mem_read   (mem_mem_read),
        .mem_mem_write  (mem_mem_write),
        .mem_wb_sel     (mem_wb_sel)
    );

    memory_stage #(
        .dmem_words (dmem_words)
    ) memory_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_dst        (mem_dst),
        .mem_reg_write  (mem_reg_write),
        .mem_mem_read   (mem_mem_read),
        .mem_mem_write  (mem_mem_write),
        .mem_wb_sel     (mem_wb_sel),
        .st_en          (st_en),
        .st_addr        (st_addr),
        .st_data        (st_data),
        .wb_reg_write   (memwb_reg_write),
        .wb_dst         (memwb_dst),
        .wb_alu         (memwb_alu),
        .wb_load        (memwb_load),
        .wb_sel         (memwb_sel)
    );

    ////////////////////////////////////////////////////////////
    // writeback
    ////////////////////////////////////////////////////////////

    assign wb_data = (memwb_sel == wb_mem) ? memwb_load : memwb_alu;
    assign wb_reg  = memwb_dst;
    // writes to r0 are dropped
    assign wb_en   = memwb_reg_write && (memwb_dst != '0);

endmodule

`default_nettype wire

//--- mips_core_tb.sv
`default_nettype none

module mips_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int max_words = 256;

    logic     clk;
    logic     arst_n;
    word_t    imem_addr;
    word_t    imem_data;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     st_en;
    word_t    st_addr;
    word_t    st_data;

    word_t    prog [max_words];
    int       prog_len = 0;
    word_t    word_addr;
    logic     testdata_loaded = 1'b0;

    // expected traces in program order
    reg_idx_t exp_wb_reg [$];
    word_t    exp_wb_data [$];
    word_t    exp_st_addr [$];
    word_t    exp_st_data [$];

    mips_core #(
        .dmem_words (256)
    ) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .st_en     (st_en),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

    always #5 clk = ~clk;

    // same-cycle instruction memory with nops past the end
    assign word_addr = imem_addr >> 2;

    always_comb begin
        if (word_addr < word_t'(prog_len)) begin
            imem_data = prog[word_addr[7:0]];
        end else begin
            imem_data = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // failure and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_wb(input reg_idx_t got_reg, input word_t got_data);
        reg_idx_t want_reg;
        word_t    want_data;
        if (exp_wb_reg.size() == 0) begin
            stop_with_failure($sformatf("unexpected register write to r%0d with value %h",
                got_reg, got_data));
        end else begin
            want_reg  = exp_wb_reg.pop_front();
            want_data = exp_wb_data.pop_front();
            if (got_reg !== want_reg) begin
                stop_with_failure($sformatf("Fail wb_reg: got %h, expected %h",
                    got_reg, want_reg));
            end else if (got_data !== want_data) begin
                stop_with_failure($sformatf("Fail wb_data (r%0d): got %h, expected %h",
                    got_reg, got_data, want_data));
            end
        end
    endtask

    task automatic check_st(input word_t got_addr, input word_t got_data);
        word_t want_addr;
        word_t want_data;
        if (exp_st_addr.size() == 0) begin
            stop_with_failure($sformatf("unexpected store to address %h with data %h",
                got_addr, got_data));
        end else begin
            want_addr = exp_st_addr.pop_front();
            want_data = exp_st_data.pop_front();
            if (got_addr !== want_addr) begin
                stop_with_failure($sformatf("Fail st_addr: got %h, expected %h",
                    got_addr, want_addr));
            end else if (got_data !== want_data) begin
                stop_with_failure($sformatf("Fail st_data: got %h, expected %h",
                    got_data, want_data));
            end
        end
    endtask

    // line tag i for program words, w for writebacks and s for stores
    task automatic load_testdata();
        int    fd;
        int    n;
        byte   tag;
        string rest;
        word_t a;
        word_t b;
        fd = $fopen("mips_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open mips_testdata.txt");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "#") begin
                    n = $fgets(rest, fd);
                end else if (tag == "i" && prog_len < max_words) begin
                    n = $fscanf(fd, "%h", a);
                    if (n != 1) begin
                        stop_with_failure("unreadable program word in testdata");
                    end else begin
                        prog[prog_len[7:0]] = a;
                        prog_len++;
                    end
                end else if (tag == "w") begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) begin
                        stop_with_failure("unreadable writeback entry in testdata");
                    end else begin
                        exp_wb_reg.push_back(a[4:0]);
                        exp_wb_data.push_back(b);
                    end
                end else if (tag == "s") begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) begin
                        stop_with_failure("unreadable store entry in testdata");
                    end else begin
                        exp_st_addr.push_back(a);
                        exp_st_data.push_back(b);
                    end
                end else begin
                    stop_with_failure("bad line or too many program words in testdata");
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitors
    ////////////////////////////////////////////////////////////

    // values sampled from before the edge updates
    always @(posedge clk) begin
        if (arst_n && wb_en) begin
            check_wb(wb_reg, wb_data);
        end
    end

    always @(posedge clk) begin
        if (arst_n && st_en) begin
            check_st(st_addr, st_data);
        end
    end

    // the closing self-jump keeps fetch inside the program
    always @(posedge clk) begin
        if (arst_n && imem_addr >= word_t'(prog_len * 4)) begin
            stop_with_failure($sformatf("fetch address %h ran past the end of the program",
                imem_addr));
        end
    end

    // main sequence
    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        load_testdata();
        testdata_loaded = 1'b1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        while (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) begin
            @(posedge clk);
        end
        // self-jump loop must stay quiet
        repeat (10) @(posedge clk);
        $display("No errors");
        $finish;
    end

    // watchdog scaled to the program length
    initial begin
        int watchdog_ns;
        wait (testdata_loaded);
        watchdog_ns = (prog_len + 50) * 40;
        #(watchdog_ns);
        stop_with_failure("timeout: expected writeback and store trace did not complete");
    end

endmodule

`default_nettype wire

//--- mips_testdata.txt
# i <word>: program word in hex, in address order from 0
# w <reg> <value>: expected writeback, s <addr> <data>: expected store
i 20010005
i 2002000c
i 2003fffd
i 20000007
i 00222020
i 00222822
i 00223024
i 00223825
i 0061402a
i 0023482a
i ac440008
i 00875020
i 8c4c0008
i 200b0001
i 01416820
i 01817020
# beq taken, 0x48 skipped
i 10210002
i 200f000f
i 20100010
# bne not taken
i 14210002
i 20110011
i 20120012
# j to 0x64, 0x60 skipped
i 08000019
i 20130013
i 20140014
i ac0e0000
i 0800001a
i 00000000
w 01 00000005
w 02 0000000c
w 03 fffffffd
w 04 00000011
w 05 fffffff9
w 06 00000004
w 07 0000000d
w 08 00000001
w 09 00000000
w 0a 0000001e
w 0c 00000011
w 0b 00000001
w 0d 00000023
w 0e 00000016
w 0f 0000000f
w 11 00000011
w 12 00000012
w 13 00000013
s 00000014 00000011
s 00000000 00000016

//--- compile.f
mips_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
mips_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mips_core_tb -f compile.f -o mips_sim \
    && ./obj_dir/mips_sim \
    || exit 1
